/* src/ext_mem_cfg_pkg.sv */
package ext_mem_cfg_pkg;

   // Bus widths
   localparam int ADDR_W = 16;  // Byte address
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;
   localparam int BYTE_OFF_W = 2;  // Byte offset in a word

   // Control region select
   localparam int CTRL_BIT = 15;

   // L1 geometry, one word per line
   localparam int L1_INDEX_W = 4;
   localparam int L1_LINES = 2 ** L1_INDEX_W;
   localparam int L1_TAG_W = ADDR_W - L1_INDEX_W - BYTE_OFF_W;

   // L2 geometry, four words per line
   localparam int L2_INDEX_W = 4;
   localparam int L2_OFFSET_W = 2;
   localparam int L2_LINES = 2 ** L2_INDEX_W;
   localparam int L2_WORDS = 2 ** (L2_INDEX_W + L2_OFFSET_W);  // Data array depth
   localparam int L2_TAG_W = ADDR_W - L2_INDEX_W - L2_OFFSET_W - BYTE_OFF_W;

endpackage

/* src/cache_ctrl_pkg.sv */
package cache_ctrl_pkg;

   // Controller states, shared by all caches
   typedef enum logic [2:0] {
      IDLE,
      LOOKUP,
      REFILL,
      WRITE,
      DONE,
      REFILL_WORD,  // L2 only
      INVAL         // L2 only
   } cache_state_e;

   // Opcode in address bits 3:2 of a control write
   typedef enum logic [1:0] {
      CTRL_NOP,
      CTRL_INV_L1D,
      CTRL_INV_L2,
      CTRL_INV_ALL
   } ctrl_op_e;

endpackage

/* src/icache.sv */
`timescale 1ns/1ns

module icache (
   input  logic                               clk_i,
   input  logic                               arst_i,
   input  logic                               req_i,
   input  logic [ext_mem_cfg_pkg::ADDR_W-1:0] addr_i,
   output logic [ext_mem_cfg_pkg::DATA_W-1:0] rdata_o,
   output logic                               ack_o,
   output logic                               be_req_o,
   output logic [ext_mem_cfg_pkg::ADDR_W-1:0] be_addr_o,
   input  logic [ext_mem_cfg_pkg::DATA_W-1:0] be_rdata_i,
   input  logic                               be_ack_i
);
   import ext_mem_cfg_pkg::*;
   import cache_ctrl_pkg::*;

   cache_state_e state_q;

   logic [DATA_W-1:0]   data_q [L1_LINES];
   logic [L1_TAG_W-1:0] tag_q  [L1_LINES];
   logic [L1_LINES-1:0] valid_q;

   logic [L1_INDEX_W-1:0] idx;
   logic [L1_TAG_W-1:0]   tag;
   logic                  hit;

   // Address held stable by the requester until ack
   assign idx = addr_i[BYTE_OFF_W +: L1_INDEX_W];
   assign tag = addr_i[ADDR_W-1 -: L1_TAG_W];
   assign hit = valid_q[idx] && (tag_q[idx] == tag);
   assign be_addr_o = {addr_i[ADDR_W-1:BYTE_OFF_W], {BYTE_OFF_W{1'b0}}};  // Word aligned

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q  <= IDLE;
         ack_o    <= 1'b0;
         be_req_o <= 1'b0;
         valid_q  <= '0;
      end else begin
         case (state_q)
            IDLE: if (req_i) state_q <= LOOKUP;
            LOOKUP: begin
               if (hit) begin
                  ack_o   <= 1'b1;  // Second edge after req
                  state_q <= DONE;
               end else begin
                  be_req_o <= 1'b1;  // Single word fetch
                  state_q  <= REFILL;
               end
            end
            REFILL: begin
               if (be_ack_i) begin
                  be_req_o     <= 1'b0;
                  valid_q[idx] <= 1'b1;
                  ack_o        <= 1'b1;
                  state_q      <= DONE;
               end
            end
            DONE: begin
               // Back end must also be idle before the next lookup
               if (!req_i && !be_ack_i) begin
                  ack_o   <= 1'b0;
                  state_q <= IDLE;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   // Line storage and read data
   always_ff @(posedge clk_i) begin
      if (state_q == REFILL && be_ack_i) begin
         data_q[idx] <= be_rdata_i;
         tag_q[idx]  <= tag;
         rdata_o     <= be_rdata_i;  // Forward refill word
      end else if (state_q == LOOKUP && hit) begin
         rdata_o <= data_q[idx];
      end
   end

endmodule

/* src/dcache.sv */
`timescale 1ns/1ns

module dcache (
   input  logic                               clk_i,
   input  logic                               arst_i,
   input  logic                               req_i,
   input  logic                               we_i,
   input  logic [ext_mem_cfg_pkg::ADDR_W-1:0] addr_i,
   input  logic [ext_mem_cfg_pkg::DATA_W-1:0] wdata_i,
   input  logic [ext_mem_cfg_pkg::STRB_W-1:0] wstrb_i,
   output logic [ext_mem_cfg_pkg::DATA_W-1:0] rdata_o,
   output logic                               ack_o,
   output logic                               be_req_o,
   output logic                               be_we_o,
   output logic [ext_mem_cfg_pkg::ADDR_W-1:0] be_addr_o,
   output logic [ext_mem_cfg_pkg::DATA_W-1:0] be_wdata_o,
   output logic [ext_mem_cfg_pkg::STRB_W-1:0] be_wstrb_o,
   input  logic [ext_mem_cfg_pkg::DATA_W-1:0] be_rdata_i,
   input  logic                               be_ack_i,
   output logic                               l2_inv_o
);
   import ext_mem_cfg_pkg::*;
   import cache_ctrl_pkg::*;

   cache_state_e state_q;

   logic [DATA_W-1:0]   data_q [L1_LINES];
   logic [L1_TAG_W-1:0] tag_q  [L1_LINES];
   logic [L1_LINES-1:0] valid_q;

   logic [L1_INDEX_W-1:0] idx;
   logic [L1_TAG_W-1:0]   tag;
   logic                  hit;
   logic                  ctrl_wr;  // Write into the control region
   ctrl_op_e              op;

   assign idx     = addr_i[BYTE_OFF_W +: L1_INDEX_W];
   assign tag     = addr_i[ADDR_W-1 -: L1_TAG_W];
   assign hit     = valid_q[idx] && (tag_q[idx] == tag);
   assign ctrl_wr = we_i && addr_i[CTRL_BIT];
   assign op      = ctrl_op_e'(addr_i[BYTE_OFF_W +: 2]);

   // Back end carries the front-end payload, write only in WRITE
   assign be_we_o    = (state_q == WRITE);
   assign be_addr_o  = {addr_i[ADDR_W-1:BYTE_OFF_W], {BYTE_OFF_W{1'b0}}};
   assign be_wdata_o = wdata_i;
   assign be_wstrb_o = wstrb_i;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q  <= IDLE;
         ack_o    <= 1'b0;
         be_req_o <= 1'b0;
         l2_inv_o <= 1'b0;
         valid_q  <= '0;
      end else begin
         l2_inv_o <= 1'b0;  // One cycle pulse
         case (state_q)
            IDLE: if (req_i) state_q <= LOOKUP;
            LOOKUP: begin
               if (ctrl_wr) begin
                  // Never reaches the back end
                  ack_o   <= 1'b1;
                  state_q <= DONE;
                  case (op)
                     CTRL_INV_L1D: valid_q <= '0;
                     CTRL_INV_L2: l2_inv_o <= 1'b1;
                     CTRL_INV_ALL: begin
                        valid_q  <= '0;
                        l2_inv_o <= 1'b1;
                     end
                     default: ;  // CTRL_NOP
                  endcase
               end else if (we_i) begin
                  be_req_o <= 1'b1;  // Write through, no allocate
                  state_q  <= WRITE;
               end else if (hit) begin
                  ack_o   <= 1'b1;
                  state_q <= DONE;
               end else begin
                  be_req_o <= 1'b1;
                  state_q  <= REFILL;
               end
            end
            REFILL: begin
               if (be_ack_i) begin
                  be_req_o     <= 1'b0;
                  valid_q[idx] <= 1'b1;
                  ack_o        <= 1'b1;
                  state_q      <= DONE;
               end
            end
            WRITE: begin
               if (be_ack_i) begin
                  be_req_o <= 1'b0;
                  ack_o    <= 1'b1;
                  state_q  <= DONE;
               end
            end
            DONE: begin
               if (!req_i && !be_ack_i) begin
                  ack_o   <= 1'b0;
                  state_q <= IDLE;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == REFILL && be_ack_i) begin
         data_q[idx] <= be_rdata_i;
         tag_q[idx]  <= tag;
         rdata_o     <= be_rdata_i;
      end else if (state_q == LOOKUP && !we_i && hit) begin
         rdata_o <= data_q[idx];
      end else if (state_q == LOOKUP && we_i && !ctrl_wr && hit) begin
         // Byte merge into the cached word
         for (int b = 0; b < STRB_W; b++) begin
            if (wstrb_i[b]) data_q[idx][8*b +: 8] <= wdata_i[8*b +: 8];
         end
      end
   end

endmodule

/* src/bus_merge.sv */
`timescale 1ns/1ns

module bus_merge (
   input  logic                               clk_i,
   input  logic                               arst_i,
   // Instruction cache master, read only
   input  logic                               ic_req_i,
   input  logic [ext_mem_cfg_pkg::ADDR_W-1:0] ic_addr_i,
   output logic [ext_mem_cfg_pkg::DATA_W-1:0] ic_rdata_o,
   output logic                               ic_ack_o,
   // Data cache master
   input  logic                               dc_req_i,
   input  logic                               dc_we_i,
   input  logic [ext_mem_cfg_pkg::ADDR_W-1:0] dc_addr_i,
   input  logic [ext_mem_cfg_pkg::DATA_W-1:0] dc_wdata_i,
   input  logic [ext_mem_cfg_pkg::STRB_W-1:0] dc_wstrb_i,
   output logic [ext_mem_cfg_pkg::DATA_W-1:0] dc_rdata_o,
   output logic                               dc_ack_o,
   // Slave side
   output logic                               s_req_o,
   output logic                               s_we_o,
   output logic [ext_mem_cfg_pkg::ADDR_W-1:0] s_addr_o,
   output logic [ext_mem_cfg_pkg::DATA_W-1:0] s_wdata_o,
   output logic [ext_mem_cfg_pkg::STRB_W-1:0] s_wstrb_o,
   input  logic [ext_mem_cfg_pkg::DATA_W-1:0] s_rdata_i,
   input  logic                               s_ack_i
);
   import ext_mem_cfg_pkg::*;

   logic busy_q;  // Handshake in progress
   logic gnt_q;   // Locked grant, 1 is dcache
   logic last_q;  // Last served master
   logic sel;

   // Round robin when free, locked grant otherwise
   assign sel = busy_q ? gnt_q : (dc_req_i && (!ic_req_i || !last_q));

   assign s_req_o   = sel ? dc_req_i : ic_req_i;
   assign s_we_o    = sel && dc_we_i;  // icache never writes
   assign s_addr_o  = sel ? dc_addr_i : ic_addr_i;
   assign s_wdata_o = sel ? dc_wdata_i : '0;
   assign s_wstrb_o = sel ? dc_wstrb_i : '0;

   // Response only to the granted master
   assign ic_ack_o   = busy_q && !gnt_q && s_ack_i;
   assign dc_ack_o   = busy_q && gnt_q && s_ack_i;
   assign ic_rdata_o = gnt_q ? '0 : s_rdata_i;
   assign dc_rdata_o = gnt_q ? s_rdata_i : '0;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         busy_q <= 1'b0;
         gnt_q  <= 1'b0;
         last_q <= 1'b0;
      end else if (!busy_q && s_req_o) begin
         busy_q <= 1'b1;
         gnt_q  <= sel;
         last_q <= sel;  // Other master wins the next tie
      end else if (busy_q && !s_req_o && !s_ack_i) begin
         busy_q <= 1'b0;  // Slave ack fell
      end
   end

endmodule

/* src/l2_cache.sv */
`timescale 1ns/1ns

module l2_cache (
   input  logic                               clk_i,
   input  logic                               arst_i,
   input  logic                               req_i,
   input  logic                               we_i,
   input  logic [ext_mem_cfg_pkg::ADDR_W-1:0] addr_i,
   input  logic [ext_mem_cfg_pkg::DATA_W-1:0] wdata_i,
   input  logic [ext_mem_cfg_pkg::STRB_W-1:0] wstrb_i,
   output logic [ext_mem_cfg_pkg::DATA_W-1:0] rdata_o,
   output logic                               ack_o,
   input  logic                               inv_i,
   output logic                               mem_req_o,
   output logic                               mem_we_o,
   output logic [ext_mem_cfg_pkg::ADDR_W-1:0] mem_addr_o,
   output logic [ext_mem_cfg_pkg::DATA_W-1:0] mem_wdata_o,
   output logic [ext_mem_cfg_pkg::STRB_W-1:0] mem_wstrb_o,
   input  logic [ext_mem_cfg_pkg::DATA_W-1:0] mem_rdata_i,
   input  logic                               mem_ack_i
);
   import ext_mem_cfg_pkg::*;
   import cache_ctrl_pkg::*;

   cache_state_e state_q;

   logic [DATA_W-1:0]   data_q [L2_WORDS];
   logic [L2_TAG_W-1:0] tag_q  [L2_LINES];
   logic [L2_LINES-1:0] valid_q;

   logic [L2_OFFSET_W-1:0] cnt_q;      // Refill word
   logic [L2_INDEX_W-1:0]  inv_idx_q;  // Line being cleared
   logic                   inv_pend_q;

   logic [L2_OFFSET_W-1:0] off;
   logic [L2_INDEX_W-1:0]  idx;
   logic [L2_TAG_W-1:0]    tag;
   logic                   hit;

   assign off = addr_i[BYTE_OFF_W +: L2_OFFSET_W];
   assign idx = addr_i[BYTE_OFF_W+L2_OFFSET_W +: L2_INDEX_W];
   assign tag = addr_i[ADDR_W-1 -: L2_TAG_W];
   assign hit = valid_q[idx] && (tag_q[idx] == tag);

   // Refill walks the line, a write uses the request address
   assign mem_addr_o  = (state_q == WRITE) ?
                        {addr_i[ADDR_W-1:BYTE_OFF_W], {BYTE_OFF_W{1'b0}}} :
                        {tag, idx, cnt_q, {BYTE_OFF_W{1'b0}}};
   assign mem_we_o    = (state_q == WRITE);
   assign mem_wdata_o = wdata_i;
   assign mem_wstrb_o = (state_q == WRITE) ? wstrb_i : '0;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q    <= IDLE;
         ack_o      <= 1'b0;
         mem_req_o  <= 1'b0;
         valid_q    <= '0;
         cnt_q      <= '0;
         inv_idx_q  <= '0;
         inv_pend_q <= 1'b0;
      end else begin
         case (state_q)
            IDLE: begin
               if (req_i) begin
                  state_q <= LOOKUP;
               end else if (inv_pend_q) begin
                  inv_pend_q <= 1'b0;  // No request in flight
                  inv_idx_q  <= '0;
                  state_q    <= INVAL;
               end
            end
            LOOKUP: begin
               if (we_i) begin
                  mem_req_o <= 1'b1;
                  state_q   <= WRITE;
               end else if (hit) begin
                  ack_o   <= 1'b1;
                  state_q <= DONE;
               end else begin
                  cnt_q   <= '0;
                  state_q <= REFILL;
               end
            end
            REFILL: begin
               // Wait for the previous word's ack to fall
               if (!mem_ack_i) begin
                  mem_req_o <= 1'b1;
                  state_q   <= REFILL_WORD;
               end
            end
            REFILL_WORD: begin
               if (mem_ack_i) begin
                  mem_req_o <= 1'b0;
                  cnt_q     <= cnt_q + 1'b1;
                  if (cnt_q == '1) begin
                     valid_q[idx] <= 1'b1;
                     state_q      <= LOOKUP;  // Line complete, retry as a hit
                  end else begin
                     state_q <= REFILL;
                  end
               end
            end
            WRITE: begin
               if (mem_ack_i) begin
                  mem_req_o <= 1'b0;
                  ack_o     <= 1'b1;
                  state_q   <= DONE;
               end
            end
            DONE: begin
               if (!req_i && !mem_ack_i) begin
                  ack_o   <= 1'b0;
                  state_q <= IDLE;
               end
            end
            INVAL: begin
               valid_q[inv_idx_q] <= 1'b0;  // One line per cycle
               inv_idx_q          <= inv_idx_q + 1'b1;
               if (inv_idx_q == '1) state_q <= IDLE;
            end
            default: state_q <= IDLE;
         endcase
         if (inv_i) inv_pend_q <= 1'b1;  // Latched until IDLE and no req
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == REFILL_WORD && mem_ack_i) begin
         data_q[{idx, cnt_q}] <= mem_rdata_i;
         tag_q[idx]           <= tag;
      end else if (state_q == LOOKUP && we_i && hit) begin
         for (int b = 0; b < STRB_W; b++) begin
            if (wstrb_i[b]) data_q[{idx, off}][8*b +: 8] <= wdata_i[8*b +: 8];
         end
      end
      if (state_q == LOOKUP && hit) rdata_o <= data_q[{idx, off}];
   end

endmodule

/* src/ext_mem.sv */
`timescale 1ns/1ns

module ext_mem (
   input  logic                               clk_i,
   input  logic                               arst_i,
   // Instruction port
   input  logic                               i_req_i,
   input  logic [ext_mem_cfg_pkg::ADDR_W-1:0] i_addr_i,
   output logic [ext_mem_cfg_pkg::DATA_W-1:0] i_rdata_o,
   output logic                               i_ack_o,
   // Data port
   input  logic                               d_req_i,
   input  logic                               d_we_i,
   input  logic [ext_mem_cfg_pkg::ADDR_W-1:0] d_addr_i,
   input  logic [ext_mem_cfg_pkg::DATA_W-1:0] d_wdata_i,
   input  logic [ext_mem_cfg_pkg::STRB_W-1:0] d_wstrb_i,
   output logic [ext_mem_cfg_pkg::DATA_W-1:0] d_rdata_o,
   output logic                               d_ack_o,
   // Word memory port
   output logic                               mem_req_o,
   output logic                               mem_we_o,
   output logic [ext_mem_cfg_pkg::ADDR_W-1:0] mem_addr_o,
   output logic [ext_mem_cfg_pkg::DATA_W-1:0] mem_wdata_o,
   output logic [ext_mem_cfg_pkg::STRB_W-1:0] mem_wstrb_o,
   input  logic [ext_mem_cfg_pkg::DATA_W-1:0] mem_rdata_i,
   input  logic                               mem_ack_i
);
   import ext_mem_cfg_pkg::*;

   // icache back end
   logic              ic_req, ic_ack;
   logic [ADDR_W-1:0] ic_addr;
   logic [DATA_W-1:0] ic_rdata;

   // dcache back end
   logic              dc_req, dc_we, dc_ack;
   logic [ADDR_W-1:0] dc_addr;
   logic [DATA_W-1:0] dc_wdata, dc_rdata;
   logic [STRB_W-1:0] dc_wstrb;

   // Merged bus into L2
   logic              l2_req, l2_we, l2_ack;
   logic [ADDR_W-1:0] l2_addr;
   logic [DATA_W-1:0] l2_wdata, l2_rdata;
   logic [STRB_W-1:0] l2_wstrb;
   logic              l2_inv;  // From dcache control region

   icache u_icache (
      .clk_i(clk_i), .arst_i(arst_i),
      .req_i(i_req_i), .addr_i(i_addr_i), .rdata_o(i_rdata_o), .ack_o(i_ack_o),
      .be_req_o(ic_req), .be_addr_o(ic_addr), .be_rdata_i(ic_rdata), .be_ack_i(ic_ack)
   );

   dcache u_dcache (
      .clk_i(clk_i), .arst_i(arst_i),
      .req_i(d_req_i), .we_i(d_we_i), .addr_i(d_addr_i),
      .wdata_i(d_wdata_i), .wstrb_i(d_wstrb_i), .rdata_o(d_rdata_o), .ack_o(d_ack_o),
      .be_req_o(dc_req), .be_we_o(dc_we), .be_addr_o(dc_addr),
      .be_wdata_o(dc_wdata), .be_wstrb_o(dc_wstrb),
      .be_rdata_i(dc_rdata), .be_ack_i(dc_ack),
      .l2_inv_o(l2_inv)
   );

   bus_merge u_bus_merge (
      .clk_i(clk_i), .arst_i(arst_i),
      .ic_req_i(ic_req), .ic_addr_i(ic_addr), .ic_rdata_o(ic_rdata), .ic_ack_o(ic_ack),
      .dc_req_i(dc_req), .dc_we_i(dc_we), .dc_addr_i(dc_addr),
      .dc_wdata_i(dc_wdata), .dc_wstrb_i(dc_wstrb),
      .dc_rdata_o(dc_rdata), .dc_ack_o(dc_ack),
      .s_req_o(l2_req), .s_we_o(l2_we), .s_addr_o(l2_addr),
      .s_wdata_o(l2_wdata), .s_wstrb_o(l2_wstrb),
      .s_rdata_i(l2_rdata), .s_ack_i(l2_ack)
   );

   l2_cache u_l2_cache (
      .clk_i(clk_i), .arst_i(arst_i),
      .req_i(l2_req), .we_i(l2_we), .addr_i(l2_addr),
      .wdata_i(l2_wdata), .wstrb_i(l2_wstrb), .rdata_o(l2_rdata), .ack_o(l2_ack),
      .inv_i(l2_inv),
      .mem_req_o(mem_req_o), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
      .mem_wdata_o(mem_wdata_o), .mem_wstrb_o(mem_wstrb_o),
      .mem_rdata_i(mem_rdata_i), .mem_ack_i(mem_ack_i)
   );

endmodule

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ns

module tb_clk_gen #(
   parameter int PERIOD_NS = 4  // Full clock period
) (
   output logic clk_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;  // Half period per phase
   end

endmodule

/* verif/tb_ext_mem.sv */
`timescale 1ns/1ns

module tb_ext_mem;
   import ext_mem_cfg_pkg::*;
   import cache_ctrl_pkg::*;

   localparam int MEM_WORDS = 4096;  // Image below word 2048, data above
   localparam int N_FETCH   = 192;
   localparam int N_RW      = 80;    // Write then read pairs
   localparam int N_MIX     = 200;   // Per port
   localparam int N_DIRECT  = 10;    // L1 hit and invalidation accesses
   localparam int N_ACCESS  = N_FETCH + 2 * N_RW + 2 * N_MIX + N_DIRECT;

   logic              clk, arst;
   logic              i_req, i_ack;
   logic [ADDR_W-1:0] i_addr;
   logic [DATA_W-1:0] i_rdata;
   logic              d_req, d_we, d_ack;
   logic [ADDR_W-1:0] d_addr;
   logic [DATA_W-1:0] d_wdata, d_rdata;
   logic [STRB_W-1:0] d_wstrb;
   logic              mem_req, mem_we, mem_ack;
   logic [ADDR_W-1:0] mem_addr;
   logic [DATA_W-1:0] mem_wdata, mem_rdata;
   logic [STRB_W-1:0] mem_wstrb;

   logic [DATA_W-1:0] mem_model [MEM_WORDS];
   logic [DATA_W-1:0] shadow    [MEM_WORDS];  // Expected memory image

   // Outstanding responses in issue order
   logic [DATA_W-1:0] i_exp_q[$], d_exp_q[$];
   logic [ADDR_W-1:0] i_addr_q[$], d_addr_q[$];
   bit                d_rd_q[$];  // Read or write

   logic [DATA_W-1:0] exp_v;
   logic [ADDR_W-1:0] addr_v;
   logic              i_ack_d = 1'b0;
   logic              d_ack_d = 1'b0;
   int                err_cnt = 0;
   int                chk_cnt = 0;
   int                mem_req_cnt = 0;  // Memory port handshakes seen
   int                errs_before;
   int                rnd;

   tb_clk_gen #(.PERIOD_NS(4)) u_clk_gen (.clk_o(clk));

   ext_mem i_dut (
      .clk_i(clk), .arst_i(arst),
      .i_req_i(i_req), .i_addr_i(i_addr), .i_rdata_o(i_rdata), .i_ack_o(i_ack),
      .d_req_i(d_req), .d_we_i(d_we), .d_addr_i(d_addr), .d_wdata_i(d_wdata),
      .d_wstrb_i(d_wstrb), .d_rdata_o(d_rdata), .d_ack_o(d_ack),
      .mem_req_o(mem_req), .mem_we_o(mem_we), .mem_addr_o(mem_addr),
      .mem_wdata_o(mem_wdata), .mem_wstrb_o(mem_wstrb),
      .mem_rdata_i(mem_rdata), .mem_ack_i(mem_ack)
   );

   // Preload pattern over all 12 word address bits
   function automatic logic [DATA_W-1:0] fill_word(input logic [11:0] w);
      return {4'hc, w, 4'h3, ~w};
   endfunction

   // A write replaces only the bytes under its strobe
   function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
         input logic [DATA_W-1:0] new_w, input logic [STRB_W-1:0] strb);
      logic [DATA_W-1:0] mask;
      mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
      return (old_w & ~mask) | (new_w & mask);
   endfunction

   // Reference model of a read
   function automatic logic [DATA_W-1:0] expected_word(input logic [ADDR_W-1:0] a);
      return shadow[a[13:2]];
   endfunction

   function automatic logic [ADDR_W-1:0] word_addr(input logic [11:0] w);
      return {2'b00, w, 2'b00};
   endfunction

   task automatic fetch(input logic [ADDR_W-1:0] a);
      i_exp_q.push_back(expected_word(a));
      i_addr_q.push_back(a);
      @(negedge clk);
      i_addr = a;
      i_req  = 1'b1;
      @(negedge clk);
      while (!i_ack) @(negedge clk);
      i_req = 1'b0;
      while (i_ack) @(negedge clk);  // Four-phase, ack must fall first
   endtask

   task automatic data_access(input logic we, input logic [ADDR_W-1:0] a,
         input logic [DATA_W-1:0] wd, input logic [STRB_W-1:0] strb);
      if (we && !a[CTRL_BIT]) shadow[a[13:2]] = merge_bytes(shadow[a[13:2]], wd, strb);
      d_rd_q.push_back(!we);
      d_exp_q.push_back(expected_word(a));
      d_addr_q.push_back(a);
      @(negedge clk);
      d_we    = we;
      d_addr  = a;
      d_wdata = wd;
      d_wstrb = strb;
      d_req   = 1'b1;
      @(negedge clk);
      while (!d_ack) @(negedge clk);
      d_req = 1'b0;
      while (d_ack) @(negedge clk);
   endtask

   task automatic data_read(input logic [ADDR_W-1:0] a);
      data_access(1'b0, a, '0, '0);
   endtask

   task automatic data_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] wd,
         input logic [STRB_W-1:0] strb);
      data_access(1'b1, a, wd, strb);
   endtask

   task automatic fetch_image();
      int r;
      for (int k = 0; k < 128; k++) fetch(word_addr(k[11:0]));
      for (int k = 0; k < N_FETCH - 128; k++) begin
         r = $urandom_range(31, 0);  // Small window, many repeats
         fetch(word_addr({7'd0, r[4:0]}));
      end
   endtask

   task automatic write_read_random();
      int r;
      int s;
      for (int k = 0; k < N_RW; k++) begin
         r = $urandom_range(31, 0);
         s = $urandom;
         data_write(word_addr({1'b1, 6'd0, r[4:0]}), $urandom, s[3:0]);
         r = $urandom_range(31, 0);
         data_read(word_addr({1'b1, 6'd0, r[4:0]}));
      end
      // Write through everywhere, so memory equals the shadow
      for (int w = 0; w < MEM_WORDS; w++) begin
         chk_cnt++;
         assert (mem_model[w] == shadow[w]) else begin
            $display("MISMATCH %0t ns mem_model[%0d] expected %h got %h",
                     $time, w, shadow[w], mem_model[w]);
            err_cnt++;
         end
      end
   endtask

   task automatic mix_ports();
      int ri;
      int rd;
      fork
         for (int k = 0; k < N_MIX; k++) begin
            ri = $urandom;
            fetch(word_addr({6'd0, ri[5:0]}));
         end
         for (int k = 0; k < N_MIX; k++) begin
            rd = $urandom;
            if (rd[31]) data_write(word_addr({1'b1, 5'd0, rd[5:0]}), $urandom, rd[9:6]);
            else data_read(word_addr({1'b1, 5'd0, rd[5:0]}));
         end
      join
   endtask

   task automatic l1_hit_quiet();
      int cnt;
      fetch(word_addr(12'h200));
      data_read(word_addr(12'h900));
      // L2 emptied, so only an L1 hit avoids the memory port
      data_write({1'b1, 11'd0, CTRL_INV_L2, 2'b00}, '0, '0);
      cnt = mem_req_cnt;
      fetch(word_addr(12'h200));  // Served by the icache alone
      assert (mem_req_cnt == cnt) else begin
         $display("%0t ns: an instruction L1 hit reached the memory port", $time);
         err_cnt++;
      end
      cnt = mem_req_cnt;
      data_read(word_addr(12'h900));
      assert (mem_req_cnt == cnt) else begin
         $display("%0t ns: a data L1 hit reached the memory port", $time);
         err_cnt++;
      end
   endtask

   task automatic invalidate_and_reread();
      logic [11:0]       w;
      logic [DATA_W-1:0] new_w;
      w     = 12'ha00;
      new_w = ~shadow[w];
      data_read(word_addr(w));  // Line now held in L1 and L2
      mem_model[w] = new_w;     // Changed behind the caches
      data_write({1'b1, 11'd0, CTRL_INV_L1D, 2'b00}, '0, '0);
      data_read(word_addr(w));  // L2 still holds the old word
      shadow[w] = new_w;
      data_write({1'b1, 11'd0, CTRL_INV_ALL, 2'b00}, '0, '0);
      data_read(word_addr(w));
   endtask

   task automatic report(input int num, input string name);
      if (err_cnt == errs_before) $display("Test %0d %s: ok", num, name);
      else $display("Test %0d %s: %0d errors", num, name, err_cnt - errs_before);
   endtask

   // Four-phase memory slave, 0 to 3 cycles before ack
   initial begin : mem_responder
      int          delay;
      logic [11:0] w;
      mem_ack   = 1'b0;
      mem_rdata = '0;
      forever begin
         @(negedge clk);
         if (mem_req === 1'b1) begin
            mem_req_cnt++;
            assert (mem_addr[15:14] == 2'b00) else begin
               $display("%0t ns: memory access at %h is outside the model", $time, mem_addr);
               err_cnt++;
            end
            delay = $urandom_range(3, 0);
            repeat (delay) @(negedge clk);
            w = mem_addr[13:2];
            if (mem_we) mem_model[w] = merge_bytes(mem_model[w], mem_wdata, mem_wstrb);
            else mem_rdata = mem_model[w];
            mem_ack = 1'b1;
            while (mem_req) @(negedge clk);
            mem_ack = 1'b0;
         end
      end
   end

   // Compare on the rising edge of each port's ack
   always @(negedge clk) begin
      if (i_ack && !i_ack_d) begin
         assert (i_exp_q.size() != 0) else begin
            $display("%0t ns: instruction ack with no request outstanding", $time);
            err_cnt++;
         end
         if (i_exp_q.size() != 0) begin
            exp_v  = i_exp_q.pop_front();
            addr_v = i_addr_q.pop_front();
            chk_cnt++;
            assert (i_rdata == exp_v) else begin
               $display("MISMATCH %0t ns i_rdata_o at %h expected %h got %h",
                        $time, addr_v, exp_v, i_rdata);
               err_cnt++;
            end
         end
      end
      if (d_ack && !d_ack_d) begin
         assert (d_rd_q.size() != 0) else begin
            $display("%0t ns: data ack with no request outstanding", $time);
            err_cnt++;
         end
         if (d_rd_q.size() != 0) begin
            exp_v  = d_exp_q.pop_front();
            addr_v = d_addr_q.pop_front();
            if (d_rd_q.pop_front()) begin  // Writes carry no data back
               chk_cnt++;
               assert (d_rdata == exp_v) else begin
                  $display("MISMATCH %0t ns d_rdata_o at %h expected %h got %h",
                           $time, addr_v, exp_v, d_rdata);
                  err_cnt++;
               end
            end
         end
      end
      i_ack_d = i_ack;
      d_ack_d = d_ack;
   end

   // Watchdog, 200 ns per access
   initial begin
      #(N_ACCESS * 200);
      $display("Timeout after %0d ns, an access never completed", N_ACCESS * 200);
      $display("=== FAIL ===");
      $finish;
   end

   initial begin
      rnd     = $urandom(32'hcbfe);  // One seed for the whole run
      arst    = 1'b1;
      i_req   = 1'b0;
      i_addr  = '0;
      d_req   = 1'b0;
      d_we    = 1'b0;
      d_addr  = '0;
      d_wdata = '0;
      d_wstrb = '0;
      for (int w = 0; w < MEM_WORDS; w++) begin
         mem_model[w] = fill_word(w[11:0]);
         shadow[w]    = fill_word(w[11:0]);
      end
      repeat (8) @(negedge clk);
      arst = 1'b0;
      errs_before = err_cnt;
      fetch_image();
      report(1, "instruction fetch");
      errs_before = err_cnt;
      write_read_random();
      report(2, "data write and read");
      errs_before = err_cnt;
      mix_ports();
      report(3, "concurrent ports");
      errs_before = err_cnt;
      l1_hit_quiet();
      report(4, "L1 hit isolation");
      errs_before = err_cnt;
      invalidate_and_reread();
      report(5, "cache invalidation");
      $display("Summary: %0d checks, %0d errors", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

/* build.f */
src/ext_mem_cfg_pkg.sv
src/cache_ctrl_pkg.sv
src/icache.sv
src/dcache.sv
src/bus_merge.sv
src/l2_cache.sv
src/ext_mem.sv
verif/tb_clk_gen.sv
verif/tb_ext_mem.sv

/* Makefile */
SIM = obj_dir/Vtb_ext_mem

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): build.f $(wildcard src/*.sv) $(wildcard verif/*.sv)
	verilator --binary --timing --assert -f build.f --top-module tb_ext_mem

# The log decides pass or fail
run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q '^=== PASS ===$$' sim.log

clean:
	rm -rf obj_dir sim.log
